// File: Bender.yml
package:
  name: msoc_periph

sources:
  - common/msoc_bus_pkg.sv
  - common/msoc_periph_pkg.sv
  - common/periph_req_if.sv
  - periph/event_fifo.sv
  - periph/periph_access_stage.sv
  - rtl/bus_decode_stage.sv
  - rtl/msoc_periph_top.sv
  - target: test
    files:
      - testbench/msoc_periph_asserts.sv
      - testbench/tb_msoc_periph.sv

// File: common/msoc_bus_pkg.sv
/* core data bus types and the device slot map
   the slot field is address bits 23:20, so sixteen slots of 1 MiB each */

package msoc_bus_pkg;

  // ------------------------------------------------------------
  // bus widths
  // ------------------------------------------------------------
  typedef logic [31:0] bus_addr_t;  // core data address
  typedef logic [31:0] bus_data_t;  // read and write data word
  typedef logic [3:0]  bus_be_t;    // one enable per byte lane

  // ------------------------------------------------------------
  // device slots
  // ------------------------------------------------------------
  typedef logic [3:0] slot_t;

  localparam int unsigned SLOT_LSB  = 20;  // slot field is addr[23:20]
  localparam int unsigned NUM_SLOTS = 16;

  localparam slot_t SLOT_UART_RX  = 4'd3;  // serial receive queue
  localparam slot_t SLOT_BOARD_IO = 4'd7;  // leds and dip switches
  localparam slot_t SLOT_KEYB     = 4'd9;  // keyboard queue

endpackage : msoc_bus_pkg

// File: common/msoc_periph_pkg.sv
/* peripheral payloads and the queue status word
   the count field is 12 bits wide, so a queue holds at most 4095 entries */

package msoc_periph_pkg;

  typedef struct packed {
    logic       err;   // framing error on this byte
    logic [7:0] data;
  } uart_entry_t;

  typedef struct packed {
    logic [6:0] ascii;
    logic [7:0] scan;
  } keyb_entry_t;

  typedef logic [15:0] led_t;
  typedef logic [7:0]  dip_t;

  localparam int unsigned FIFO_DEPTH_DEF = 16;
  localparam int unsigned STAT_CNT_W     = 12;
  localparam int unsigned STAT_HEAD_W    = 16;

  // queue status word, msb first
  typedef struct packed {
    logic                   overflow;   // bit 31, sticky
    logic                   underflow;  // bit 30, sticky
    logic                   full;       // bit 29
    logic                   empty;      // bit 28
    logic [STAT_CNT_W-1:0]  count;      // bits 27:16
    logic [STAT_HEAD_W-1:0] head;       // bits 15:0, zero-extended
  } status_t;

endpackage : msoc_periph_pkg

// File: common/periph_req_if.sv
/* registered request between the two bus stages
   valid is a one-cycle strobe and there is no back-pressure */

`timescale 1ns/1ps

interface periph_req_if;

  logic                    valid;  // one cycle per accepted request
  logic                    we;
  msoc_bus_pkg::slot_t     slot;
  msoc_bus_pkg::bus_be_t   be;
  msoc_bus_pkg::bus_data_t wdata;

  // decode side
  modport stage (
    output valid, we, slot, be, wdata
  );

  // access side
  modport access (
    input valid, we, slot, be, wdata
  );

endinterface : periph_req_if

// File: msoc_periph_top.f
common/msoc_bus_pkg.sv
common/msoc_periph_pkg.sv
common/periph_req_if.sv
periph/event_fifo.sv
periph/periph_access_stage.sv
rtl/bus_decode_stage.sv
rtl/msoc_periph_top.sv
testbench/msoc_periph_asserts.sv
testbench/tb_msoc_periph.sv

// File: periph/event_fifo.sv
/* single-clock queue, one push and one pop per cycle
   a push when full and a pop when empty are dropped and set sticky flags */

`timescale 1ns/1ps

module event_fifo #(
  parameter int unsigned DEPTH   = 16,
  parameter type         entry_t = logic [7:0],
  localparam int unsigned CNT_W  = $clog2(DEPTH + 1)
) (
  input  logic             msoc_clk,
  input  logic             rstn,
  input  logic             push_i,
  input  entry_t           entry_i,
  input  logic             pop_i,
  output entry_t           head_o,
  output logic [CNT_W-1:0] count_o,
  output logic             full_o,
  output logic             empty_o,
  output logic             overflow_o,
  output logic             underflow_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  entry_t           mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic             do_push, do_pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;  // wrap for any depth
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_o == CNT_W'(DEPTH));
  assign empty_o = (count_o == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign head_o  = empty_o ? entry_t'('0) : mem[rd_ptr];  // empty queue shows zero

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count_o     <= '0;
      overflow_o  <= 1'b0;
      underflow_o <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_next(rd_ptr);
      if (do_push && !do_pop)
        count_o <= count_o + 1'b1;
      else if (do_pop && !do_push)
        count_o <= count_o - 1'b1;
      if (push_i && full_o)
        overflow_o <= 1'b1;   // sticky
      if (pop_i && empty_o)
        underflow_o <= 1'b1;  // sticky
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= entry_i;
  end

endmodule : event_fifo

// File: periph/periph_access_stage.sv
/* second bus stage, slot writes and queue pops plus the registered read response
   a write to a queue slot pops its head, the read word is taken before the pop */

`timescale 1ns/1ps

module periph_access_stage #(
  parameter int unsigned FIFO_DEPTH = msoc_periph_pkg::FIFO_DEPTH_DEF
) (
  input  logic                          msoc_clk,
  input  logic                          rstn,
  periph_req_if.access                  stage_i,
  input  logic                          uart_push_i,
  input  msoc_periph_pkg::uart_entry_t  uart_entry_i,
  input  logic                          keyb_push_i,
  input  msoc_periph_pkg::keyb_entry_t  keyb_entry_i,
  input  msoc_periph_pkg::dip_t         dip_i,
  output msoc_periph_pkg::led_t         led_o,
  output logic                          rvalid_o,
  output msoc_bus_pkg::bus_data_t       rdata_o
);

  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned NS    = msoc_bus_pkg::NUM_SLOTS;

  logic [NS-1:0]                slot_sel;
  msoc_bus_pkg::bus_data_t      slot_rdata [NS];
  msoc_bus_pkg::bus_data_t      rd_mux;
  msoc_periph_pkg::dip_t        dip_q;
  msoc_periph_pkg::status_t     uart_stat, keyb_stat;
  msoc_periph_pkg::uart_entry_t uart_head;
  msoc_periph_pkg::keyb_entry_t keyb_head;
  logic [CNT_W-1:0]             uart_count, keyb_count;
  logic uart_pop, uart_full, uart_empty, uart_ovf, uart_udf;
  logic keyb_pop, keyb_full, keyb_empty, keyb_ovf, keyb_udf;

  assign slot_sel = stage_i.valid ? (NS'(1) << stage_i.slot) : '0;
  assign uart_pop = slot_sel[msoc_bus_pkg::SLOT_UART_RX] & stage_i.we;
  assign keyb_pop = slot_sel[msoc_bus_pkg::SLOT_KEYB] & stage_i.we;

  event_fifo #(
    .DEPTH   (FIFO_DEPTH),
    .entry_t (msoc_periph_pkg::uart_entry_t)
  ) u_uart_fifo (
    .msoc_clk, .rstn, .push_i (uart_push_i), .entry_i (uart_entry_i), .pop_i (uart_pop),
    .head_o (uart_head), .count_o (uart_count), .full_o (uart_full), .empty_o (uart_empty),
    .overflow_o (uart_ovf), .underflow_o (uart_udf)
  );

  event_fifo #(
    .DEPTH   (FIFO_DEPTH),
    .entry_t (msoc_periph_pkg::keyb_entry_t)
  ) u_keyb_fifo (
    .msoc_clk, .rstn, .push_i (keyb_push_i), .entry_i (keyb_entry_i), .pop_i (keyb_pop),
    .head_o (keyb_head), .count_o (keyb_count), .full_o (keyb_full), .empty_o (keyb_empty),
    .overflow_o (keyb_ovf), .underflow_o (keyb_udf)
  );

  // ------------------------------------------------------------
  // read word assembly
  // ------------------------------------------------------------
  assign uart_stat = '{uart_ovf, uart_udf, uart_full, uart_empty,
                       msoc_periph_pkg::STAT_CNT_W'(uart_count),
                       msoc_periph_pkg::STAT_HEAD_W'(uart_head)};
  assign keyb_stat = '{keyb_ovf, keyb_udf, keyb_full, keyb_empty,
                       msoc_periph_pkg::STAT_CNT_W'(keyb_count),
                       msoc_periph_pkg::STAT_HEAD_W'(keyb_head)};

  always_comb
  begin
    for (int i = 0; i < NS; i++)
    begin
      slot_rdata[i] = '0;  // unmapped slots read zero
    end
    slot_rdata[msoc_bus_pkg::SLOT_UART_RX]  = uart_stat;
    slot_rdata[msoc_bus_pkg::SLOT_KEYB]     = keyb_stat;
    slot_rdata[msoc_bus_pkg::SLOT_BOARD_IO] = 32'(dip_q);
    rd_mux = '0;
    for (int i = 0; i < NS; i++)
    begin
      rd_mux |= slot_sel[i] ? slot_rdata[i] : '0;
    end
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rvalid_o <= 1'b0;
      led_o    <= '0;
      dip_q    <= '0;
    end
    else
    begin
      rvalid_o <= stage_i.valid;
      dip_q    <= dip_i;  // single sync stage
      if (slot_sel[msoc_bus_pkg::SLOT_BOARD_IO] && stage_i.we)
      begin
        for (int b = 0; b < $bits(msoc_periph_pkg::led_t) / 8; b++)
        begin
          if (stage_i.be[b])
            led_o[b*8 +: 8] <= stage_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    rdata_o <= rd_mux;
  end

endmodule : periph_access_stage

// File: rtl/bus_decode_stage.sv
/* first bus stage, grants every request and registers it with the slot index
   only address bits 23:20 are decoded, the rest of the address is ignored */

`timescale 1ns/1ps

module bus_decode_stage (
  input  logic                    msoc_clk,
  input  logic                    rstn,
  input  logic                    req_i,
  input  msoc_bus_pkg::bus_addr_t addr_i,
  input  logic                    we_i,
  input  msoc_bus_pkg::bus_be_t   be_i,
  input  msoc_bus_pkg::bus_data_t wdata_i,
  output logic                    gnt_o,
  periph_req_if.stage             stage_o
);

  msoc_bus_pkg::slot_t slot;

  // no slot can stall, so every request is taken at once
  assign gnt_o = req_i;

  assign slot = addr_i[msoc_bus_pkg::SLOT_LSB +: $bits(msoc_bus_pkg::slot_t)];

  // ------------------------------------------------------------
  // request register
  // ------------------------------------------------------------
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      stage_o.valid <= 1'b0;
    end
    else
    begin
      stage_o.valid <= req_i;  // single-cycle strobe per request
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (req_i)
    begin
      stage_o.we    <= we_i;
      stage_o.slot  <= slot;
      stage_o.be    <= be_i;
      stage_o.wdata <= wdata_i;
    end
  end

endmodule : bus_decode_stage

// File: rtl/msoc_periph_top.sv
/* peripheral side of the core data port, two-stage pipeline
   rvalid follows every grant by exactly two cycles, the core must take each response */

`timescale 1ns/1ps

module msoc_periph_top #(
  parameter int unsigned FIFO_DEPTH = msoc_periph_pkg::FIFO_DEPTH_DEF
) (
  input  logic                          msoc_clk,
  input  logic                          rstn,
  input  logic                          data_req_i,
  input  msoc_bus_pkg::bus_addr_t       data_addr_i,
  input  logic                          data_we_i,
  input  msoc_bus_pkg::bus_be_t         data_be_i,
  input  msoc_bus_pkg::bus_data_t       data_wdata_i,
  output logic                          data_gnt_o,
  output logic                          data_rvalid_o,
  output msoc_bus_pkg::bus_data_t       data_rdata_o,
  input  logic                          uart_push_i,
  input  msoc_periph_pkg::uart_entry_t  uart_entry_i,
  input  logic                          keyb_push_i,
  input  msoc_periph_pkg::keyb_entry_t  keyb_entry_i,
  input  msoc_periph_pkg::dip_t         dip_i,
  output msoc_periph_pkg::led_t         led_o
);

  periph_req_if req_if ();  // decode -> access

  bus_decode_stage u_decode (
    .msoc_clk (msoc_clk),
    .rstn     (rstn),
    .req_i    (data_req_i),
    .addr_i   (data_addr_i),
    .we_i     (data_we_i),
    .be_i     (data_be_i),
    .wdata_i  (data_wdata_i),
    .gnt_o    (data_gnt_o),
    .stage_o  (req_if.stage)
  );

  periph_access_stage #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_access (
    .msoc_clk     (msoc_clk),
    .rstn         (rstn),
    .stage_i      (req_if.access),
    .uart_push_i  (uart_push_i),
    .uart_entry_i (uart_entry_i),
    .keyb_push_i  (keyb_push_i),
    .keyb_entry_i (keyb_entry_i),
    .dip_i        (dip_i),
    .led_o        (led_o),
    .rvalid_o     (data_rvalid_o),
    .rdata_o      (data_rdata_o)
  );

endmodule : msoc_periph_top

// File: testbench/msoc_periph_asserts.sv
/* handshake checks on the core data port, bound into the top level
   the two-cycle rule holds only while no request is cut short by reset */

`timescale 1ns/1ps

module msoc_periph_asserts (
  input logic msoc_clk,
  input logic rstn,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i
);

  // no slot stalls, so every request is granted at once
  gnt_eq_req: assert property (@(posedge msoc_clk) disable iff (!rstn) gnt_i == req_i)
    else $error("grant differs from request");

  // ------------------------------------------------------------
  // response timing
  // ------------------------------------------------------------
  gnt_to_rvalid: assert property (@(posedge msoc_clk) disable iff (!rstn)
    gnt_i |-> ##2 rvalid_i)
    else $error("no rvalid two cycles after a grant");

  rvalid_from_gnt: assert property (@(posedge msoc_clk) disable iff (!rstn)
    rvalid_i |-> $past(gnt_i, 2))
    else $error("rvalid without a grant two cycles earlier");

  rvalid_in_reset: assert property (@(posedge msoc_clk) !rstn |-> !rvalid_i)
    else $error("rvalid high during reset");

endmodule : msoc_periph_asserts

bind msoc_periph_top msoc_periph_asserts u_asserts (
  .msoc_clk (msoc_clk),
  .rstn     (rstn),
  .req_i    (data_req_i),
  .gnt_i    (data_gnt_o),
  .rvalid_i (data_rvalid_o)
);

// File: testbench/periph_cases.txt
# columns: op addr arg data, all hex. W write (arg = byte enables), R read after a gap, Q read with no gap
# U/K push arg entries counting up from data, D dip value, L expected led; data of R/Q is the expected word
R 00300000 0 10000000
R 80500004 0 00000000
W 00700000 3 0000a55a
L 00000000 0 0000a55a
W 00700000 2 00003c00
L 00000000 0 00003c5a
D 00000000 0 000000c3
R 00700000 0 000000c3
U 00000000 3 00000141
Q 00300000 0 00030141
K 00000000 2 00005a1c
R 00900000 0 00025a1c
W 00300000 f 00000000
Q 00300000 0 00020142
Q 00900000 0 00025a1c
U 00000000 e 00000010
R 00300000 0 20100142
U 00000000 1 000000ff
R 00300000 0 a0100142
W 00300000 0 00000000
Q 00300000 0 800f0143
W 00900000 0 00000000
W 00900000 0 00000000
W 00900000 0 00000000
Q 00900000 0 50000000

// File: testbench/tb_msoc_periph.sv
/* testbench for the peripheral data port, driven by testbench/periph_cases.txt
   must run from the project root, the queue depth is the package default */

`timescale 1ns/1ps

module tb_msoc_periph;

  logic                         msoc_clk;
  logic                         rstn;
  logic                         data_req_i;
  msoc_bus_pkg::bus_addr_t      data_addr_i;
  logic                         data_we_i;
  msoc_bus_pkg::bus_be_t        data_be_i;
  msoc_bus_pkg::bus_data_t      data_wdata_i;
  logic                         data_gnt_o;
  logic                         data_rvalid_o;
  msoc_bus_pkg::bus_data_t      data_rdata_o;
  logic                         uart_push_i;
  msoc_periph_pkg::uart_entry_t uart_entry_i;
  logic                         keyb_push_i;
  msoc_periph_pkg::keyb_entry_t keyb_entry_i;
  msoc_periph_pkg::dip_t        dip_i;
  msoc_periph_pkg::led_t        led_o;

  logic [7:0]              op_q [$];
  msoc_bus_pkg::bus_addr_t addr_q [$];
  logic [31:0]             arg_q [$];     // byte enables or push count
  msoc_bus_pkg::bus_data_t data_q [$];
  logic                    pend_we [$];   // issued, not granted yet
  msoc_bus_pkg::bus_data_t pend_exp [$];
  logic                    fl_we [$];     // granted, waiting for rvalid
  msoc_bus_pkg::bus_data_t fl_exp [$];
  int unsigned             fl_cyc [$];

  logic [31:0] lfsr = 32'h5b7565c6;
  int unsigned mon_cyc, run_cyc, cycle_limit;
  int          outstanding;
  int          rdata_errs, led_errs, timing_errs, other_errs;

  msoc_periph_top dut (.*);

  initial
  begin
    msoc_clk = 1'b0;
    forever #4 msoc_clk = ~msoc_clk;
  end

  always @(posedge msoc_clk)
  begin
    run_cyc++;
    if (cycle_limit != 0 && run_cyc > cycle_limit)
    begin
      $display("timeout, the test did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_rdata(input msoc_bus_pkg::bus_data_t exp,
                             input msoc_bus_pkg::bus_data_t got);
    if (got !== exp)
    begin
      rdata_errs++;
      $display("mismatch data_rdata_o: expected 0x%08h got 0x%08h", exp, got);
    end
  endtask

  task automatic check_led(input msoc_periph_pkg::led_t exp, input msoc_periph_pkg::led_t got);
    if (got !== exp)
    begin
      led_errs++;
      $display("mismatch led_o: expected 0x%04h got 0x%04h", exp, got);
    end
  endtask

  task automatic check_rvalid_cycle(input int unsigned grant_cyc, input int unsigned resp_cyc);
    if (resp_cyc - grant_cyc != 2)
    begin
      timing_errs++;
      $display("mismatch data_rvalid_o latency: expected 0x2 got 0x%0h", resp_cyc - grant_cyc);
    end
  endtask

  // ------------------------------------------------------------
  // response monitor, sampled on the falling edge
  // ------------------------------------------------------------
  always @(negedge msoc_clk)
  begin
    mon_cyc++;
    if (rstn)
    begin
      while (fl_cyc.size() > 0 && fl_cyc[0] + 2 < mon_cyc)
      begin
        $display("no rvalid arrived for the request granted in cycle %0d", fl_cyc[0]);
        timing_errs++;
        outstanding--;
        fl_cyc.delete(0);
        fl_we.delete(0);
        fl_exp.delete(0);
      end
      if (data_rvalid_o && fl_cyc.size() == 0)
      begin
        $display("rvalid in cycle %0d without a granted request", mon_cyc);
        timing_errs++;
      end
      else if (data_rvalid_o)
      begin
        check_rvalid_cycle(fl_cyc[0], mon_cyc);
        if (!fl_we[0])
          check_rdata(fl_exp[0], data_rdata_o);  // writes carry no read data
        outstanding--;
        fl_cyc.delete(0);
        fl_we.delete(0);
        fl_exp.delete(0);
      end
      if (data_gnt_o && pend_we.size() == 0)
      begin
        $display("grant in cycle %0d without an issued request", mon_cyc);
        timing_errs++;
      end
      else if (data_gnt_o)
      begin
        fl_cyc.push_back(mon_cyc);
        fl_we.push_back(pend_we[0]);
        fl_exp.push_back(pend_exp[0]);
        pend_we.delete(0);
        pend_exp.delete(0);
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic pick_gap(output int gap);
    gap = 0;
    repeat (2)
    begin
      lfsr = lfsr_next(lfsr);
      gap = (gap << 1) | lfsr[0];
    end
  endtask

  task automatic start_cycle;
    @(posedge msoc_clk);
    data_req_i  <= 1'b0;
    uart_push_i <= 1'b0;
    keyb_push_i <= 1'b0;
  endtask

  task automatic issue_bus(input logic we, input msoc_bus_pkg::bus_addr_t addr,
                           input msoc_bus_pkg::bus_be_t be, input msoc_bus_pkg::bus_data_t data);
    start_cycle();
    data_req_i   <= 1'b1;
    data_we_i    <= we;
    data_addr_i  <= addr;
    data_be_i    <= be;
    data_wdata_i <= we ? data : '0;
    pend_we.push_back(we);
    pend_exp.push_back(data);
    outstanding++;
  endtask

  task automatic load_cases(output bit ok);
    int               fd;
    int               code;
    logic [7:0]       op;
    logic [31:0]      addr, arg, data;
    logic [8*160-1:0] rest;
    ok = 1'b0;
    fd = $fopen("testbench/periph_cases.txt", "r");
    if (fd == 0)
      return;
    while (!$feof(fd))
    begin
      code = $fscanf(fd, " %c", op);
      if (code != 1)
        break;
      if (op == "#")
        code = $fgets(rest, fd);  // rest of a comment line
      else
      begin
        code = $fscanf(fd, "%h %h %h", addr, arg, data);
        if (code != 3)
        begin
          $display("case file line for operation %s is incomplete", op);
          other_errs++;
          break;
        end
        op_q.push_back(op);
        addr_q.push_back(addr);
        arg_q.push_back(arg);
        data_q.push_back(data);
      end
    end
    $fclose(fd);
    ok = (op_q.size() > 0);
  endtask

  task automatic run_cases;
    int         i;
    int         j;
    int         gap;
    logic [7:0] op;
    for (i = 0; i < op_q.size(); i++)
    begin
      op = op_q[i];
      if (op == "W" || op == "R")
      begin
        pick_gap(gap);
        repeat (gap) start_cycle();
      end
      case (op)
        "W": issue_bus(1'b1, addr_q[i], arg_q[i][3:0], data_q[i]);
        "R", "Q": issue_bus(1'b0, addr_q[i], '0, data_q[i]);
        "U":
          for (j = 0; j < arg_q[i]; j++)
          begin
            start_cycle();
            uart_push_i  <= 1'b1;
            uart_entry_i <= data_q[i][8:0] + 9'(j);
          end
        "K":
          for (j = 0; j < arg_q[i]; j++)
          begin
            start_cycle();
            keyb_push_i  <= 1'b1;
            keyb_entry_i <= data_q[i][14:0] + 15'(j);
          end
        "D":
        begin
          start_cycle();
          dip_i <= data_q[i][7:0];
        end
        "L":
        begin
          start_cycle();
          wait (outstanding == 0);  // earlier writes have landed
          @(negedge msoc_clk);
          check_led(data_q[i][15:0], led_o);
        end
        default:
        begin
          $display("unknown operation %s in the case file", op);
          other_errs++;
        end
      endcase
    end
  endtask

  initial
  begin
    bit ok;
    rstn         <= 1'b0;
    data_req_i   <= 1'b0;
    data_addr_i  <= '0;
    data_we_i    <= 1'b0;
    data_be_i    <= '0;
    data_wdata_i <= '0;
    uart_push_i  <= 1'b0;
    uart_entry_i <= '0;
    keyb_push_i  <= 1'b0;
    keyb_entry_i <= '0;
    dip_i        <= '0;
    load_cases(ok);
    if (!ok)
    begin
      $display("the case file testbench/periph_cases.txt could not be read");
      $display("Simulation failed");
      $finish;
    end
    else
    begin
      cycle_limit = 20 * op_q.size() + 100;
      repeat (2) @(posedge msoc_clk);
      rstn <= 1'b1;
      run_cases();
      start_cycle();
      wait (outstanding == 0);
      repeat (4) @(posedge msoc_clk);  // catch late or extra responses
      $display("errors: rdata %0d, led %0d, timing %0d, other %0d",
               rdata_errs, led_errs, timing_errs, other_errs);
      if (rdata_errs + led_errs + timing_errs + other_errs == 0)
        $display("Simulation completed successfully");
      else
        $display("Simulation failed");
      $finish;
    end
  end

endmodule : tb_msoc_periph
